// File: Makefile
# Verilator build and run of the stream decimation testbench

SIM := obj_dir/Vtb_stream_decim

all: run

$(SIM): flist.f $(wildcard hw/*.sv hw/*.svh tests/*.sv tests/*.svh)
	verilator --binary --timing --assert --timescale 1ns/1ns \
	  -f flist.f --top-module tb_stream_decim -Mdir obj_dir -o Vtb_stream_decim

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "sim passed"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: flist.f
+incdir+hw
+incdir+tests
hw/stream_pkg.sv
hw/stream_decimator.sv
hw/credit_tx.sv
hw/credit_fifo.sv
hw/stream_egress.sv
hw/stream_decim_top.sv
tests/tb_stream_decim.sv

// File: hw/credit_fifo.sv
/*
  Credit FIFO
  Circular buffer sized to the credit pool. Its head drives the egress,
  and each popped entry returns one credit to the transmitter a cycle later
*/

`timescale 1ns/1ns
`include "stream_macros.svh"

module credit_fifo
(
  input  logic                           clk,
  input  logic                           reset,

  input  logic                           link_push,
  input  logic [`STREAM_DATA_WIDTH-1:0]  link_data,
  input  logic                           link_sop,
  input  logic                           link_eop,
  input  logic [`STREAM_EMPTY_WIDTH-1:0] link_empty,
  output logic                           credit_return,

  output logic                           fifo_valid,
  output logic [`STREAM_DATA_WIDTH-1:0]  fifo_data,
  output logic                           fifo_sop,
  output logic                           fifo_eop,
  output logic [`STREAM_EMPTY_WIDTH-1:0] fifo_empty,
  input  logic                           fifo_pop
);

  import stream_pkg::*;

  localparam int DEPTH     = `STREAM_FIFO_DEPTH;
  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(DEPTH - 1);

  // Entry storage, one array per field
  logic [`STREAM_DATA_WIDTH-1:0]  mem_data  [DEPTH];
  logic                           mem_sop   [DEPTH];
  logic                           mem_eop   [DEPTH];
  logic [`STREAM_EMPTY_WIDTH-1:0] mem_empty [DEPTH];

  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  credit_count_t        occupancy;

  // ******************************
  // Storage and pointers
  // ******************************

  always_ff @(posedge clk)
  begin
    if (link_push)
    begin
      mem_data[wr_ptr]  <= link_data;
      mem_sop[wr_ptr]   <= link_sop;
      mem_eop[wr_ptr]   <= link_eop;
      mem_empty[wr_ptr] <= link_empty;
    end
  end

  // Pointers wrap explicitly so the depth need not be a power of two
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end
    else
    begin
      if (link_push)
      begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + PTR_WIDTH'(1);
      end
      if (fifo_pop)
      begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + PTR_WIDTH'(1);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      occupancy <= '0;
    end
    else if (link_push && !fifo_pop)
    begin
      occupancy <= occupancy + credit_count_t'(1);
    end
    else if (!link_push && fifo_pop)
    begin
      occupancy <= occupancy - credit_count_t'(1);
    end
  end

  // Head is visible the cycle after the push edge that filled it
  assign fifo_valid = (occupancy != '0);
  assign fifo_data  = mem_data[rd_ptr];
  assign fifo_sop   = mem_sop[rd_ptr];
  assign fifo_eop   = mem_eop[rd_ptr];
  assign fifo_empty = mem_empty[rd_ptr];

  // One registered credit per freed slot
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      credit_return <= 1'b0;
    end
    else
    begin
      credit_return <= fifo_pop;
    end
  end

  // The transmitter's credit count is what keeps these from happening
  a_no_overflow: assert property (@(posedge clk) disable iff (reset)
    link_push |-> (occupancy != credit_count_t'(DEPTH)));

  a_no_underflow: assert property (@(posedge clk) disable iff (reset)
    fifo_pop |-> (occupancy != '0));

endmodule

// File: hw/credit_tx.sv
/*
  Credit transmitter
  Accepts beats from the decimator only while a FIFO credit is held and
  pushes them onto the link, spending one credit per push
*/

`timescale 1ns/1ns
`include "stream_macros.svh"

module credit_tx
(
  input  logic                           clk,
  input  logic                           reset,

  input  logic [`STREAM_DATA_WIDTH-1:0]  in_data,
  input  logic                           in_valid,
  input  logic                           in_sop,
  input  logic                           in_eop,
  input  logic [`STREAM_EMPTY_WIDTH-1:0] in_empty,
  output logic                           in_ready,

  output logic                           link_push,
  output logic [`STREAM_DATA_WIDTH-1:0]  link_data,
  output logic                           link_sop,
  output logic                           link_eop,
  output logic [`STREAM_EMPTY_WIDTH-1:0] link_empty,
  input  logic                           credit_return
);

  import stream_pkg::*;

  localparam credit_count_t FULL_CREDITS = credit_count_t'(`STREAM_FIFO_DEPTH);

  credit_count_t credits;

  // Ready as long as one FIFO slot is known to be free
  assign in_ready  = (credits != '0);
  assign link_push = in_valid && in_ready;

  assign link_data  = in_data;
  assign link_sop   = in_sop;
  assign link_eop   = in_eop;
  assign link_empty = in_empty;

  // Pool starts full, push spends, a returned credit refills.
  // Both in one cycle cancel out
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      credits <= FULL_CREDITS;
    end
    else if (link_push && !credit_return)
    begin
      credits <= credits - credit_count_t'(1);
    end
    else if (!link_push && credit_return)
    begin
      credits <= credits + credit_count_t'(1);
    end
  end

  // The FIFO must never return more credits than were spent
  a_credit_max: assert property (@(posedge clk) disable iff (reset)
    credits <= FULL_CREDITS);

  a_no_push_at_zero: assert property (@(posedge clk) disable iff (reset)
    !(link_push && (credits == '0)));

endmodule

// File: hw/stream_decim_top.sv
/*
  Stream decimation path, top level
  Decimator and credit transmitter feed the credit FIFO over the link,
  and the egress stage drains it to the output port
*/

`timescale 1ns/1ns
`include "stream_macros.svh"

module stream_decim_top
(
  input  logic                           clk,
  input  logic                           reset,

  input  logic                           csr_write,
  input  stream_pkg::csr_word_t          csr_writedata,
  input  stream_pkg::csr_be_t            csr_byteenable,
  input  logic                           csr_read,
  output stream_pkg::csr_word_t          csr_readdata,

  input  logic [`STREAM_DATA_WIDTH-1:0]  snk_data,
  input  logic                           snk_valid,
  input  logic                           snk_sop,
  input  logic                           snk_eop,
  input  logic [`STREAM_EMPTY_WIDTH-1:0] snk_empty,
  output logic                           snk_ready,

  output logic [`STREAM_DATA_WIDTH-1:0]  out_data,
  output logic                           out_valid,
  output logic                           out_sop,
  output logic                           out_eop,
  output logic [`STREAM_EMPTY_WIDTH-1:0] out_empty,
  input  logic                           out_ready,

  output stream_pkg::stat_count_t        stat_beats,
  output stream_pkg::stat_count_t        stat_packets
);

  // Decimator source into the credit transmitter
  logic [`STREAM_DATA_WIDTH-1:0]  dec_data;
  logic                           dec_valid;
  logic                           dec_sop;
  logic                           dec_eop;
  logic [`STREAM_EMPTY_WIDTH-1:0] dec_empty;
  logic                           dec_ready;

  // Credit link, forward beats and returned credits
  logic                           link_push;
  logic [`STREAM_DATA_WIDTH-1:0]  link_data;
  logic                           link_sop;
  logic                           link_eop;
  logic [`STREAM_EMPTY_WIDTH-1:0] link_empty;
  logic                           credit_return;

  // FIFO head into the egress
  logic                           fifo_valid;
  logic [`STREAM_DATA_WIDTH-1:0]  fifo_data;
  logic                           fifo_sop;
  logic                           fifo_eop;
  logic [`STREAM_EMPTY_WIDTH-1:0] fifo_empty;
  logic                           fifo_pop;

  // ******************************
  // Producer
  // ******************************

  stream_decimator u_decimator (
    .clk            (clk),
    .reset          (reset),
    .csr_write      (csr_write),
    .csr_writedata  (csr_writedata),
    .csr_byteenable (csr_byteenable),
    .csr_read       (csr_read),
    .csr_readdata   (csr_readdata),
    .snk_data       (snk_data),
    .snk_valid      (snk_valid),
    .snk_sop        (snk_sop),
    .snk_eop        (snk_eop),
    .snk_empty      (snk_empty),
    .snk_ready      (snk_ready),
    .src_data       (dec_data),
    .src_valid      (dec_valid),
    .src_sop        (dec_sop),
    .src_eop        (dec_eop),
    .src_empty      (dec_empty),
    .src_ready      (dec_ready)
  );

  credit_tx u_credit_tx (
    .clk           (clk),
    .reset         (reset),
    .in_data       (dec_data),
    .in_valid      (dec_valid),
    .in_sop        (dec_sop),
    .in_eop        (dec_eop),
    .in_empty      (dec_empty),
    .in_ready      (dec_ready),
    .link_push     (link_push),
    .link_data     (link_data),
    .link_sop      (link_sop),
    .link_eop      (link_eop),
    .link_empty    (link_empty),
    .credit_return (credit_return)
  );

  // ******************************
  // Buffer and consumer
  // ******************************

  credit_fifo u_credit_fifo (
    .clk           (clk),
    .reset         (reset),
    .link_push     (link_push),
    .link_data     (link_data),
    .link_sop      (link_sop),
    .link_eop      (link_eop),
    .link_empty    (link_empty),
    .credit_return (credit_return),
    .fifo_valid    (fifo_valid),
    .fifo_data     (fifo_data),
    .fifo_sop      (fifo_sop),
    .fifo_eop      (fifo_eop),
    .fifo_empty    (fifo_empty),
    .fifo_pop      (fifo_pop)
  );

  stream_egress u_egress (
    .clk          (clk),
    .reset        (reset),
    .fifo_valid   (fifo_valid),
    .fifo_data    (fifo_data),
    .fifo_sop     (fifo_sop),
    .fifo_eop     (fifo_eop),
    .fifo_empty   (fifo_empty),
    .fifo_pop     (fifo_pop),
    .out_data     (out_data),
    .out_valid    (out_valid),
    .out_sop      (out_sop),
    .out_eop      (out_eop),
    .out_empty    (out_empty),
    .out_ready    (out_ready),
    .stat_beats   (stat_beats),
    .stat_packets (stat_packets)
  );

endmodule

// File: hw/stream_decimator.sv
/*
  Stream decimator
  Drops a programmable number of beats for every beat forwarded, and always
  keeps start and end of packet beats. Controlled by one 64-bit register
  holding enable, decimation factor and decimation counter
*/

`timescale 1ns/1ns
`include "stream_macros.svh"

module stream_decimator
(
  input  logic                           clk,
  input  logic                           reset,

  input  logic                           csr_write,
  input  stream_pkg::csr_word_t          csr_writedata,
  input  stream_pkg::csr_be_t            csr_byteenable,
  input  logic                           csr_read,
  output stream_pkg::csr_word_t          csr_readdata,

  input  logic [`STREAM_DATA_WIDTH-1:0]  snk_data,
  input  logic                           snk_valid,
  input  logic                           snk_sop,
  input  logic                           snk_eop,
  input  logic [`STREAM_EMPTY_WIDTH-1:0] snk_empty,
  output logic                           snk_ready,

  output logic [`STREAM_DATA_WIDTH-1:0]  src_data,
  output logic                           src_valid,
  output logic                           src_sop,
  output logic                           src_eop,
  output logic [`STREAM_EMPTY_WIDTH-1:0] src_empty,
  input  logic                           src_ready
);

  import stream_pkg::*;

  logic         enable;
  decim_count_t decim_factor;
  decim_count_t decim_counter;
  logic         counter_write;
  logic         beat_accepted;

  // ******************************
  // Control register
  // ******************************

  // Byte lane 0 carries the enable bit, the rest of that lane is reserved
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      enable <= 1'b0;
    end
    else if (csr_write && csr_byteenable[0])
    begin
      enable <= csr_writedata[0];
    end
  end

  // Factor sits in lanes 2 and 3, each lane written on its own
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      decim_factor <= '0;
    end
    else if (csr_write)
    begin
      if (csr_byteenable[2])
      begin
        decim_factor[7:0] <= csr_writedata[23:16];
      end
      if (csr_byteenable[3])
      begin
        decim_factor[15:8] <= csr_writedata[31:24];
      end
    end
  end

  // A write to either counter lane wins over counting in the same cycle
  assign counter_write = csr_write && (csr_byteenable[4] || csr_byteenable[5]);

  // Software should only preload the counter while the block is disabled
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      decim_counter <= '0;
    end
    else if (counter_write)
    begin
      if (csr_byteenable[4])
      begin
        decim_counter[7:0] <= csr_writedata[39:32];
      end
      if (csr_byteenable[5])
      begin
        decim_counter[15:8] <= csr_writedata[47:40];
      end
    end
    else if (beat_accepted)
    begin
      // Modulo count, wrapping after it has matched the factor
      decim_counter <= (decim_counter == decim_factor) ? '0 : decim_counter + 16'd1;
    end
  end

  // Reserved bits 15..1 and 63..48 always read back as zero
  assign csr_readdata = {16'h0000, decim_counter, decim_factor, 15'h0000, enable};

  // ******************************
  // Beat filter
  // ******************************

  assign src_data  = snk_data;
  assign src_sop   = snk_sop;
  assign src_eop   = snk_eop;
  assign src_empty = snk_empty;

  // Nothing moves while disabled, so the sink stalls rather than dropping
  assign snk_ready = src_ready && enable;

  // The counter steps on every accepted beat, kept or not
  assign beat_accepted = snk_valid && snk_ready;

  // Keep the beat at counter zero, and every packet boundary beat
  assign src_valid = snk_valid && enable &&
                     ((decim_counter == '0) || snk_sop || snk_eop);

  // A kept beat only ever comes from a live sink beat while enabled
  a_src_valid_gated: assert property (@(posedge clk) disable iff (reset)
    src_valid |-> (snk_valid && enable));

endmodule

// File: hw/stream_egress.sv
/*
  Stream egress
  Presents the FIFO head on the output port, pops on each transfer and
  counts the beats and packets that leave
*/

`timescale 1ns/1ns
`include "stream_macros.svh"

module stream_egress
(
  input  logic                           clk,
  input  logic                           reset,

  input  logic                           fifo_valid,
  input  logic [`STREAM_DATA_WIDTH-1:0]  fifo_data,
  input  logic                           fifo_sop,
  input  logic                           fifo_eop,
  input  logic [`STREAM_EMPTY_WIDTH-1:0] fifo_empty,
  output logic                           fifo_pop,

  output logic [`STREAM_DATA_WIDTH-1:0]  out_data,
  output logic                           out_valid,
  output logic                           out_sop,
  output logic                           out_eop,
  output logic [`STREAM_EMPTY_WIDTH-1:0] out_empty,
  input  logic                           out_ready,

  output stream_pkg::stat_count_t        stat_beats,
  output stream_pkg::stat_count_t        stat_packets
);

  import stream_pkg::*;

  stat_count_t beat_count;
  stat_count_t packet_count;

  // ******************************
  // Output port
  // ******************************

  // The head entry goes straight out, no extra register stage
  assign out_valid = fifo_valid;
  assign out_data  = fifo_data;
  assign out_sop   = fifo_sop;
  assign out_eop   = fifo_eop;
  assign out_empty = fifo_empty;

  // A transfer on the output is exactly a pop of the FIFO
  assign fifo_pop = fifo_valid && out_ready;

  // ******************************
  // Statistics
  // ******************************

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      beat_count   <= '0;
      packet_count <= '0;
    end
    else if (fifo_pop)
    begin
      beat_count <= beat_count + stat_count_t'(1);
      // A packet counts once its last beat has gone out
      if (fifo_eop)
      begin
        packet_count <= packet_count + stat_count_t'(1);
      end
    end
  end

  assign stat_beats   = beat_count;
  assign stat_packets = packet_count;

endmodule

// File: hw/stream_macros.svh
/*
  Stream decimation path widths and sizes
  Beat field widths, credit FIFO depth and counter widths shared by
  the package and every RTL block
*/

`ifndef STREAM_MACROS_SVH
`define STREAM_MACROS_SVH

// ******************************
// Beat fields
// ******************************

// Beat payload width in bits
`define STREAM_DATA_WIDTH 32

// Count of unused bytes in the last beat of a packet, log2 of the bytes per beat
`define STREAM_EMPTY_WIDTH 2

// ******************************
// Buffering and statistics
// ******************************

// FIFO entries, which is also the credit pool the transmitter starts with
`define STREAM_FIFO_DEPTH 8

// Must hold the full depth value, not just depth minus one
`define STREAM_CREDIT_WIDTH 4

// Width of the beat and packet counters at the egress
`define STREAM_STAT_WIDTH 32

`endif

// File: hw/stream_pkg.sv
/*
  Stream decimation package
  Field types shared by the decimator, the credit link, the FIFO and
  the egress stage
*/

`include "stream_macros.svh"

package stream_pkg;

  // Decimation factor and the modulo counter that runs against it
  typedef logic [15:0] decim_count_t;

  // Control register word as seen on writedata and readdata
  typedef logic [63:0] csr_word_t;

  // One enable bit per byte lane of the control word
  typedef logic [7:0] csr_be_t;

  // Statistics counters at the output port
  typedef logic [`STREAM_STAT_WIDTH-1:0] stat_count_t;

  // Credits held by the transmitter, and the FIFO occupancy,
  // both range from zero up to the full depth
  typedef logic [`STREAM_CREDIT_WIDTH-1:0] credit_count_t;

endpackage

// File: tests/tb_stream_decim_table.svh
/*
  Test cases for the stream decimation testbench
  Each row programs the control register, then sends packets of the given
  shape with optional input gaps and one output stall mode
*/

  // Stall mode 0 keeps out_ready high, 1 drops it at random,
  // 2 holds it low for the first HOLD_CYCLES cycles of the test
  localparam int NUM_TESTS = 12;

  test_row_t test_table [NUM_TESTS];

  task automatic load_test_table();
    // enable, factor, preload, byte enables, length, count, gaps, stall
    // Disabled path, the sink must never accept
    test_table[0]  = '{1'b0, 16'd3, 16'd0, 8'h3D, 8'd4, 8'd2, 1'b0, 2'd0};
    // Pass-through, then single-beat packets with idle gaps
    test_table[1]  = '{1'b1, 16'd0, 16'd0, 8'h3D, 8'd5, 8'd3, 1'b0, 2'd0};
    test_table[2]  = '{1'b1, 16'd0, 16'd0, 8'h3D, 8'd1, 8'd4, 1'b1, 2'd0};
    // Decimation with and without a counter preload
    test_table[3]  = '{1'b1, 16'd2, 16'd0, 8'h3D, 8'd8, 8'd3, 1'b0, 2'd0};
    test_table[4]  = '{1'b1, 16'd3, 16'd2, 8'h3D, 8'd7, 8'd3, 1'b1, 2'd0};
    // Only the low factor lane is written, the counter keeps running on
    test_table[5]  = '{1'b1, 16'h0505, 16'd0, 8'h05, 8'd10, 8'd2, 1'b0, 2'd0};
    // Low counter lane only, random output stalls
    test_table[6]  = '{1'b1, 16'd4, 16'd1, 8'h1D, 8'd9, 8'd2, 1'b1, 2'd1};
    // Long output stall, the credit pool runs dry
    test_table[7]  = '{1'b1, 16'd1, 16'd0, 8'h3D, 8'd12, 8'd3, 1'b0, 2'd2};
    test_table[8]  = '{1'b1, 16'd0, 16'd0, 8'h3D, 8'd6, 8'd4, 1'b0, 2'd2};
    // Reserved lanes only, nothing but noise reaches the register
    test_table[9]  = '{1'b1, 16'd2, 16'd1, 8'hC2, 8'd5, 8'd3, 1'b1, 2'd1};
    // Both factor lanes with the high counter lane
    test_table[10] = '{1'b1, 16'h0102, 16'h0000, 8'h2D, 8'd6, 8'd2, 1'b0, 2'd1};
    // Disabled again after traffic
    test_table[11] = '{1'b0, 16'd1, 16'd1, 8'h3D, 8'd3, 8'd1, 1'b0, 2'd0};
  endtask

// File: tests/tb_stream_decim.sv
/*
  Testbench for the stream decimation path
  Programs the control register from a table of cases, sends packets,
  models which beats the decimator keeps and checks the output order,
  the beat fields, the register readback and the statistics
*/

`timescale 1ns/1ns
`include "stream_macros.svh"

module tb_stream_decim;

  import stream_pkg::*;

  localparam int TIMEOUT_CYCLES  = 400;
  localparam int HOLD_CYCLES     = 40;
  localparam int DISABLED_CYCLES = 30;

  typedef struct packed {
    logic         enable;
    decim_count_t factor;
    decim_count_t preload;
    csr_be_t      byteenable;
    logic [7:0]   pkt_len;
    logic [7:0]   pkt_count;
    logic         gaps;
    logic [1:0]   stall;
  } test_row_t;

  typedef struct packed {
    logic [`STREAM_DATA_WIDTH-1:0]  data;
    logic                           sop;
    logic                           eop;
    logic [`STREAM_EMPTY_WIDTH-1:0] empty;
  } beat_t;

  logic                           clk;
  logic                           reset;
  logic                           csr_write;
  csr_word_t                      csr_writedata;
  csr_be_t                        csr_byteenable;
  logic                           csr_read;
  csr_word_t                      csr_readdata;
  logic [`STREAM_DATA_WIDTH-1:0]  snk_data;
  logic                           snk_valid;
  logic                           snk_sop;
  logic                           snk_eop;
  logic [`STREAM_EMPTY_WIDTH-1:0] snk_empty;
  logic                           snk_ready;
  logic [`STREAM_DATA_WIDTH-1:0]  out_data;
  logic                           out_valid;
  logic                           out_sop;
  logic                           out_eop;
  logic [`STREAM_EMPTY_WIDTH-1:0] out_empty;
  logic                           out_ready;
  stat_count_t                    stat_beats;
  stat_count_t                    stat_packets;

  // Reference model of the control register and the kept beats
  logic                           m_enable;
  decim_count_t                   m_factor;
  decim_count_t                   m_counter;
  beat_t                          expected_q [$];
  int                             kept_beats;
  int                             kept_eops;
  int                             stalled_kept;
  int                             fail_count;
  int                             tests_failed;
  logic                           drive_done;
  logic [`STREAM_DATA_WIDTH-1:0]  data_word;

  `include "tb_stream_decim_table.svh"

  stream_decim_top UUT (
    .clk            (clk),
    .reset          (reset),
    .csr_write      (csr_write),
    .csr_writedata  (csr_writedata),
    .csr_byteenable (csr_byteenable),
    .csr_read       (csr_read),
    .csr_readdata   (csr_readdata),
    .snk_data       (snk_data),
    .snk_valid      (snk_valid),
    .snk_sop        (snk_sop),
    .snk_eop        (snk_eop),
    .snk_empty      (snk_empty),
    .snk_ready      (snk_ready),
    .out_data       (out_data),
    .out_valid      (out_valid),
    .out_sop        (out_sop),
    .out_eop        (out_eop),
    .out_empty      (out_empty),
    .out_ready      (out_ready),
    .stat_beats     (stat_beats),
    .stat_packets   (stat_packets)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ******************************
  // Helpers
  // ******************************

  // Inputs change 2 ns after the rising edge, outputs are read at the falling edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic abort_run(input string reason);
    $display("Timeout at %0t: %s", $time, reason);
    $display("sim failed");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    assert (actual === expected)
    else
    begin
      $display("Error at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      fail_count++;
    end
  endtask

  // One write cycle, with the register lanes mirrored in the model
  task automatic write_csr(input csr_word_t word, input csr_be_t be);
    csr_write      = 1'b1;
    csr_writedata  = word;
    csr_byteenable = be;
    next_cycle();
    csr_write = 1'b0;
    if (be[0])
      m_enable = word[0];
    if (be[2])
      m_factor[7:0] = word[23:16];
    if (be[3])
      m_factor[15:8] = word[31:24];
    if (be[4])
      m_counter[7:0] = word[39:32];
    if (be[5])
      m_counter[15:8] = word[47:40];
  endtask

  // Reserved bits must come back as zero whatever was written to them
  task automatic check_csr();
    csr_read = 1'b1;
    @(negedge clk);
    check_value("csr_readdata", csr_readdata,
                {16'h0000, m_counter, m_factor, 15'h0000, m_enable});
    next_cycle();
    csr_read = 1'b0;
  endtask

  // ******************************
  // Reference model
  // ******************************

  // Called for every beat the sink accepts, kept or not
  task automatic accept_beat(input test_row_t row);
    beat_t beat;
    beat = '{snk_data, snk_sop, snk_eop, snk_empty};
    // With the output held the pool only holds the FIFO depth
    if (row.stall == 2'd2 && !out_ready)
    begin
      assert (stalled_kept < `STREAM_FIFO_DEPTH)
      else
      begin
        $display("Error at %0t: the sink took a beat with every credit spent", $time);
        fail_count++;
      end
    end
    if ((m_counter == '0) || snk_sop || snk_eop)
    begin
      expected_q.push_back(beat);
      kept_beats++;
      if (snk_eop)
        kept_eops++;
      if (row.stall == 2'd2 && !out_ready)
        stalled_kept++;
    end
    m_counter = (m_counter == m_factor) ? '0 : m_counter + 16'd1;
  endtask

  // ******************************
  // Stimulus and output monitor
  // ******************************

  task automatic drive_packets(input test_row_t row);
    int   wait_count;
    int   gap;
    logic accepted;
    for (int p = 0; p < int'(row.pkt_count); p++)
    begin
      for (int b = 0; b < int'(row.pkt_len); b++)
      begin
        if (row.gaps)
        begin
          gap = int'($urandom % 4);
          snk_valid = 1'b0;
          repeat (gap) next_cycle();
        end
        snk_data  = data_word;
        snk_sop   = (b == 0);
        snk_eop   = (b == int'(row.pkt_len) - 1);
        snk_empty = snk_eop ? 2'($urandom) : '0;
        snk_valid = 1'b1;
        data_word = data_word + 1;
        accepted   = 1'b0;
        wait_count = 0;
        while (!accepted)
        begin
          @(negedge clk);
          if (snk_ready)
          begin
            accepted = 1'b1;
            accept_beat(row);
          end
          else if (wait_count == TIMEOUT_CYCLES)
            abort_run("the sink never accepted a beat");
          wait_count++;
          next_cycle();
        end
      end
    end
    snk_valid  = 1'b0;
    drive_done = 1'b1;
  endtask

  task automatic collect_output(input test_row_t row);
    int    cycle;
    int    idle;
    beat_t exp_beat;
    cycle = 0;
    idle  = 0;
    while (!drive_done || expected_q.size() != 0)
    begin
      case (row.stall)
        2'd1:    out_ready = ($urandom % 3) != 0;
        2'd2:    out_ready = (cycle >= HOLD_CYCLES);
        default: out_ready = 1'b1;
      endcase
      @(negedge clk);
      if (out_valid && out_ready)
      begin
        idle = 0;
        assert (expected_q.size() != 0)
        else
        begin
          $display("Error at %0t: beat %0h left the output with none expected",
                   $time, out_data);
          fail_count++;
        end
        if (expected_q.size() != 0)
        begin
          exp_beat = expected_q.pop_front();
          check_value("out_data", 64'(out_data), 64'(exp_beat.data));
          check_value("out_sop", 64'(out_sop), 64'(exp_beat.sop));
          check_value("out_eop", 64'(out_eop), 64'(exp_beat.eop));
          check_value("out_empty", 64'(out_empty), 64'(exp_beat.empty));
        end
      end
      else if (idle == TIMEOUT_CYCLES)
        abort_run("no beat left the output port");
      else
        idle++;
      cycle++;
      next_cycle();
    end
    out_ready = 1'b1;
  endtask

  // Valid is held the whole window, yet nothing may move
  task automatic drive_disabled();
    snk_data  = data_word;
    snk_sop   = 1'b1;
    snk_eop   = 1'b0;
    snk_empty = '0;
    snk_valid = 1'b1;
    repeat (DISABLED_CYCLES)
    begin
      @(negedge clk);
      check_value("snk_ready", 64'(snk_ready), 64'd0);
      check_value("out_valid", 64'(out_valid), 64'd0);
      next_cycle();
    end
    snk_valid = 1'b0;
  endtask

  task automatic run_test(input int index, input test_row_t row);
    stat_count_t beats_before;
    stat_count_t packets_before;
    int          fails_before;
    csr_word_t   word;
    fails_before = fail_count;
    kept_beats   = 0;
    kept_eops    = 0;
    stalled_kept = 0;
    drive_done   = 1'b0;
    // Disable, program the row with noise in the reserved bits, then enable
    write_csr(64'd0, 8'h01);
    word = {$urandom, $urandom};
    word[31:16] = row.factor;
    word[47:32] = row.preload;
    word[0] = row.enable;
    write_csr(word, row.byteenable);
    check_csr();
    write_csr({63'd0, row.enable}, 8'h01);
    check_csr();
    @(negedge clk);
    beats_before   = stat_beats;
    packets_before = stat_packets;
    next_cycle();
    if (row.enable)
    begin
      fork
        drive_packets(row);
        collect_output(row);
      join
    end
    else
    begin
      drive_disabled();
    end
    @(negedge clk);
    check_value("out_valid", 64'(out_valid), 64'd0);
    check_value("stat_beats change", 64'(stat_beats - beats_before), 64'(kept_beats));
    check_value("stat_packets change", 64'(stat_packets - packets_before), 64'(kept_eops));
    if (row.stall == 2'd2)
      check_value("beats held during the stall", 64'(stalled_kept), 64'(`STREAM_FIFO_DEPTH));
    next_cycle();
    // Counter readback shows it advanced on every accepted beat
    check_csr();
    if (fail_count == fails_before)
      $display("test %0d: ok, %0d beats kept", index, kept_beats);
    else
    begin
      $display("test %0d: %0d errors", index, fail_count - fails_before);
      tests_failed++;
    end
  endtask

  // ******************************
  // Main sequence
  // ******************************

  initial
  begin
    void'($urandom(32'h62499678));
    reset          = 1'b1;
    csr_write      = 1'b0;
    csr_writedata  = '0;
    csr_byteenable = '0;
    csr_read       = 1'b0;
    snk_data       = '0;
    snk_valid      = 1'b0;
    snk_sop        = 1'b0;
    snk_eop        = 1'b0;
    snk_empty      = '0;
    out_ready      = 1'b0;
    m_enable       = 1'b0;
    m_factor       = '0;
    m_counter      = '0;
    kept_beats     = 0;
    kept_eops      = 0;
    stalled_kept   = 0;
    fail_count     = 0;
    tests_failed   = 0;
    drive_done     = 1'b0;
    data_word      = 32'h0000_0001;
    load_test_table();
    repeat (8) @(posedge clk);
    #2;
    reset     = 1'b0;
    out_ready = 1'b1;
    next_cycle();
    // Enable resets low, so the sink and the output start idle
    @(negedge clk);
    check_value("snk_ready", 64'(snk_ready), 64'd0);
    check_value("out_valid", 64'(out_valid), 64'd0);
    next_cycle();
    check_csr();
    for (int i = 0; i < NUM_TESTS; i++)
      run_test(i, test_table[i]);
    $display("tests run %0d, tests with errors %0d, failed checks %0d",
             NUM_TESTS, tests_failed, fail_count);
    if (fail_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule
